// File: src/cpu_pkg.sv
package cpu_pkg;

   localparam int DATA_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int OPCODE_W  = 6;
   localparam int COND_W    = 4;
   localparam int NUM_REGS  = 8;
   localparam int STAGE_W   = 3;

   localparam logic [DATA_W-1:0] RESET_PC = '0;

   // last stage of each phase or instruction
   localparam logic [STAGE_W-1:0] STAGE_FIRST    = 3'd1;
   localparam logic [STAGE_W-1:0] FETCH_STAGES   = 3'd2;
   localparam logic [STAGE_W-1:0] LOADN_STAGES   = 3'd2;
   localparam logic [STAGE_W-1:0] LOAD_STAGES    = 3'd4;
   localparam logic [STAGE_W-1:0] STORE_STAGES   = 3'd5;
   localparam logic [STAGE_W-1:0] MOV_STAGES     = 3'd2;
   localparam logic [STAGE_W-1:0] JMP_STAGES     = 3'd3;
   localparam logic [STAGE_W-1:0] OUTCHAR_STAGES = 3'd3;
   localparam logic [STAGE_W-1:0] ALU_DONE_STAGE = 3'd6;

   // strobe points inside an instruction
   localparam logic [STAGE_W-1:0] STORE_WE_STAGE     = 3'd4;
   localparam logic [STAGE_W-1:0] VIDEO_STROBE_STAGE = 3'd2;

   typedef enum logic [OPCODE_W-1:0] {
      LOADN   = 6'b111000,
      LOAD    = 6'b110000,
      STORE   = 6'b110001,
      MOV     = 6'b110011,
      OUTCHAR = 6'b110010,
      JMP     = 6'b000010,
      ADD     = 6'b100000,
      SUB     = 6'b100001,
      MUL     = 6'b100010,
      DIV     = 6'b100011,
      MOD     = 6'b100101,
      AND     = 6'b010010,
      OR      = 6'b010011,
      XOR     = 6'b010100,
      CMP     = 6'b010110
   } opcode_e;

   typedef enum logic [COND_W-1:0] {
      COND_ALWAYS   = 4'd0,
      COND_EQ       = 4'd1,
      COND_NE       = 4'd2,
      COND_ZERO     = 4'd3,
      COND_NONZERO  = 4'd4,
      COND_CARRY    = 4'd5,
      COND_NOCARRY  = 4'd6,
      COND_GREATER  = 4'd7,
      COND_LESSER   = 4'd8,
      COND_GE       = 4'd9,
      COND_LE       = 4'd10,
      COND_OVERFLOW = 4'd11,
      COND_NOOVERFL = 4'd12,
      COND_NEGATIVE = 4'd13,
      COND_DIVZERO  = 4'd14
   } cond_e;

   typedef struct packed {
      opcode_e              opcode;
      logic [REG_SEL_W-1:0] rx;
      logic [REG_SEL_W-1:0] ry;
      logic [REG_SEL_W-1:0] rz;
      logic                 use_carry;
   } arith_fmt_t;

   typedef struct packed {
      logic [REG_SEL_W-1:0] rx;
      logic [REG_SEL_W-1:0] ry;
      logic [3:0]           spare;
   } mem_regs_t;

   typedef struct packed {
      cond_e      cond;
      logic [5:0] spare;
   } jump_fields_t;

   // bits 9:0 of a memory or jump word
   typedef union packed {
      mem_regs_t    regs;
      jump_fields_t jump;
   } mem_fields_u;

   typedef struct packed {
      opcode_e     opcode;
      mem_fields_u f;
   } mem_fmt_t;

   typedef union packed {
      arith_fmt_t arith;
      mem_fmt_t   mem;
   } instr_u;

   typedef struct packed {
      logic       greater;
      logic       lesser;
      logic       equal;
      logic       zero;
      logic       carry;
      logic       overflow;
      logic       divzero;
      logic [1:0] spare_hi;
      logic       negative;
      logic [5:0] spare_lo;
   } flags_t;

   typedef struct packed {
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              we;
   } mem_req_t;

   typedef struct packed {
      logic              enable;
      opcode_e           opcode;
      logic              use_carry;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
   } alu_req_t;

   typedef struct packed {
      logic              strobe;
      logic [DATA_W-1:0] pos;
      logic [DATA_W-1:0] character;
   } video_t;

endpackage

// File: src/register_file.sv
`timescale 1ns/1ns

module register_file (
   input  logic                          wire_clock,
   input  logic                          resetStage,
   input  logic [cpu_pkg::REG_SEL_W-1:0] rd_a_sel,
   input  logic [cpu_pkg::REG_SEL_W-1:0] rd_b_sel,
   output logic [cpu_pkg::DATA_W-1:0]    rd_a_data,
   output logic [cpu_pkg::DATA_W-1:0]    rd_b_data,
   input  logic                          wr_en,
   input  logic [cpu_pkg::REG_SEL_W-1:0] wr_sel,
   input  logic [cpu_pkg::DATA_W-1:0]    wr_data
);
   import cpu_pkg::*;

   logic [DATA_W-1:0] regs [NUM_REGS];

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // reads see the old value during a write cycle
   assign rd_a_data = regs[rd_a_sel];
   assign rd_b_data = regs[rd_b_sel];

endmodule

// File: src/branch_condition.sv
`timescale 1ns/1ns

module branch_condition (
   input  cpu_pkg::cond_e  cond,
   input  cpu_pkg::flags_t flags,
   output logic            take
);
   import cpu_pkg::*;

   always_comb begin
      case (cond)
         COND_ALWAYS:   take = 1'b1;
         COND_EQ:       take = flags.equal;
         COND_NE:       take = ~flags.equal;
         COND_ZERO:     take = flags.zero;
         COND_NONZERO:  take = ~flags.zero;
         COND_CARRY:    take = flags.carry;
         COND_NOCARRY:  take = ~flags.carry;
         COND_GREATER:  take = flags.greater;
         COND_LESSER:   take = flags.lesser;
         // combined compares
         COND_GE:       take = flags.greater | flags.equal;
         COND_LE:       take = flags.lesser | flags.equal;
         COND_OVERFLOW: take = flags.overflow;
         COND_NOOVERFL: take = ~flags.overflow;
         COND_NEGATIVE: take = flags.negative;
         COND_DIVZERO:  take = flags.divzero;
         default:       take = 1'b0;
      endcase
   end

endmodule

// File: src/instr_sequencer.sv
`timescale 1ns/1ns

module instr_sequencer (
   input  logic                          wire_clock,
   input  logic                          resetStage,
   output cpu_pkg::mem_req_t             mem,
   input  logic [cpu_pkg::DATA_W-1:0]    mem_rdata,
   output cpu_pkg::alu_req_t             alu,
   input  logic [cpu_pkg::DATA_W-1:0]    alu_result,
   output cpu_pkg::video_t               video,
   output logic [cpu_pkg::REG_SEL_W-1:0] rd_a_sel,
   output logic [cpu_pkg::REG_SEL_W-1:0] rd_b_sel,
   input  logic [cpu_pkg::DATA_W-1:0]    rd_a_data,
   input  logic [cpu_pkg::DATA_W-1:0]    rd_b_data,
   output logic                          wr_en,
   output logic [cpu_pkg::REG_SEL_W-1:0] wr_sel,
   output logic [cpu_pkg::DATA_W-1:0]    wr_data,
   output cpu_pkg::cond_e                cond,
   input  logic                          take
);
   import cpu_pkg::*;

   logic [STAGE_W-1:0] stage;
   logic               executing;
   logic               last_stage;
   logic [DATA_W-1:0]  pc;
   instr_u             ir;
   opcode_e            op;
   logic [DATA_W-1:0]  addr_latch;

   logic [DATA_W-1:0]  mem_addr_q;
   logic [DATA_W-1:0]  mem_wdata_q;
   logic               mem_we_q;
   logic               alu_en_q;
   opcode_e            alu_op_q;
   logic               alu_carry_q;
   logic [DATA_W-1:0]  alu_a_q;
   logic [DATA_W-1:0]  alu_b_q;
   logic               vid_strobe_q;
   logic [DATA_W-1:0]  vid_pos_q;
   logic [DATA_W-1:0]  vid_char_q;

   assign op       = ir.arith.opcode;
   assign rd_a_sel = ir.arith.rx;
   assign rd_b_sel = ir.arith.ry;
   assign cond     = ir.mem.f.jump.cond;

   // end of the current phase
   always_comb begin
      if (!executing) begin
         last_stage = (stage == FETCH_STAGES);
      end else begin
         case (op)
            LOADN:   last_stage = (stage == LOADN_STAGES);
            LOAD:    last_stage = (stage == LOAD_STAGES);
            STORE:   last_stage = (stage == STORE_STAGES);
            MOV:     last_stage = (stage == MOV_STAGES);
            JMP:     last_stage = (stage == JMP_STAGES);
            OUTCHAR: last_stage = (stage == OUTCHAR_STAGES);
            ADD, SUB, MUL, DIV, MOD, AND, OR, XOR, CMP:
               last_stage = (stage == ALU_DONE_STAGE);
            // unknown opcode is a one-stage no-op
            default: last_stage = 1'b1;
         endcase
      end
   end

   // register write port, taken by the register file on this edge
   always_comb begin
      wr_en   = 1'b0;
      wr_sel  = ir.mem.f.regs.rx;
      wr_data = mem_rdata;
      if (executing) begin
         case (op)
            LOADN: wr_en = (stage == LOADN_STAGES);
            LOAD:  wr_en = (stage == LOAD_STAGES);
            MOV: begin
               wr_en   = (stage == STAGE_FIRST);
               wr_data = rd_b_data;
            end
            ADD, SUB, MUL, DIV, MOD, AND, OR, XOR: begin
               wr_en   = (stage == ALU_DONE_STAGE);
               wr_sel  = ir.arith.rz;
               wr_data = alu_result;
            end
            default: wr_en = 1'b0;
         endcase
      end
   end

   // stage counter, pc and strobes
   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         stage        <= STAGE_FIRST;
         executing    <= 1'b0;
         pc           <= RESET_PC;
         mem_we_q     <= 1'b0;
         alu_en_q     <= 1'b0;
         vid_strobe_q <= 1'b0;
      end else begin
         stage <= last_stage ? STAGE_FIRST : stage + 1'b1;
         if (last_stage) begin
            executing <= ~executing;
         end
         if (!executing) begin
            if (stage == FETCH_STAGES) begin
               pc <= pc + 1'b1;
            end
         end else begin
            case (op)
               LOADN: begin
                  if (stage == LOADN_STAGES) begin
                     pc <= pc + 1'b1;
                  end
               end
               LOAD: begin
                  if (stage == LOAD_STAGES) begin
                     pc <= pc + 1'b1;
                  end
               end
               STORE: begin
                  if (stage == STORE_WE_STAGE) begin
                     mem_we_q <= 1'b1;
                  end
                  if (stage == STORE_STAGES) begin
                     mem_we_q <= 1'b0;
                     pc       <= pc + 1'b1;
                  end
               end
               JMP: begin
                  // target word or skip over it
                  if (stage == 3'd2) begin
                     pc <= take ? mem_rdata : pc + 1'b1;
                  end
               end
               OUTCHAR: begin
                  if (stage == VIDEO_STROBE_STAGE) begin
                     vid_strobe_q <= 1'b1;
                  end
                  if (stage == OUTCHAR_STAGES) begin
                     vid_strobe_q <= 1'b0;
                  end
               end
               ADD, SUB, MUL, DIV, MOD, AND, OR, XOR, CMP: begin
                  if (stage == STAGE_FIRST) begin
                     alu_en_q <= 1'b1;
                  end
                  if (stage == ALU_DONE_STAGE) begin
                     alu_en_q <= 1'b0;
                  end
               end
               default: pc <= pc;
            endcase
         end
      end
   end

   // instruction, address and operand registers
   always_ff @(posedge wire_clock) begin
      if (!executing) begin
         if (stage == STAGE_FIRST) begin
            mem_addr_q <= pc;
         end
         if (stage == FETCH_STAGES) begin
            ir <= mem_rdata;
         end
      end else begin
         case (op)
            LOADN, JMP: begin
               if (stage == STAGE_FIRST) begin
                  mem_addr_q <= pc;
               end
            end
            LOAD, STORE: begin
               if (stage == STAGE_FIRST) begin
                  mem_addr_q <= pc;
               end
               if (stage == 3'd2) begin
                  addr_latch <= mem_rdata;
               end
               if (stage == 3'd3) begin
                  mem_addr_q <= addr_latch;
               end
               if (op == STORE && stage == STORE_WE_STAGE) begin
                  mem_wdata_q <= rd_a_data;
               end
            end
            OUTCHAR: begin
               // settle a cycle ahead of the strobe
               if (stage == STAGE_FIRST) begin
                  vid_pos_q  <= rd_b_data;
                  vid_char_q <= rd_a_data;
               end
            end
            ADD, SUB, MUL, DIV, MOD, AND, OR, XOR, CMP: begin
               if (stage == STAGE_FIRST) begin
                  alu_a_q     <= rd_a_data;
                  alu_b_q     <= rd_b_data;
                  alu_op_q    <= op;
                  alu_carry_q <= (op == ADD || op == SUB) && ir.arith.use_carry;
               end
            end
            default: mem_addr_q <= mem_addr_q;
         endcase
      end
   end

   assign mem = '{addr: mem_addr_q, wdata: mem_wdata_q, we: mem_we_q};

   assign alu = '{enable: alu_en_q, opcode: alu_op_q, use_carry: alu_carry_q,
                  a: alu_a_q, b: alu_b_q};

   assign video = '{strobe: vid_strobe_q, pos: vid_pos_q, character: vid_char_q};

endmodule

// File: src/cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
   input  logic                       wire_clock,
   input  logic                       resetStage,
   output cpu_pkg::mem_req_t          mem,
   input  logic [cpu_pkg::DATA_W-1:0] mem_rdata,
   output cpu_pkg::alu_req_t          alu,
   input  logic [cpu_pkg::DATA_W-1:0] alu_result,
   input  cpu_pkg::flags_t            flags,
   output cpu_pkg::video_t            video
);
   import cpu_pkg::*;

   logic [REG_SEL_W-1:0] rd_a_sel;
   logic [REG_SEL_W-1:0] rd_b_sel;
   logic [DATA_W-1:0]    rd_a_data;
   logic [DATA_W-1:0]    rd_b_data;
   logic                 wr_en;
   logic [REG_SEL_W-1:0] wr_sel;
   logic [DATA_W-1:0]    wr_data;
   cond_e                cond;
   logic                 take;

   instr_sequencer u_seq (
      .wire_clock (wire_clock),
      .resetStage (resetStage),
      .mem        (mem),
      .mem_rdata  (mem_rdata),
      .alu        (alu),
      .alu_result (alu_result),
      .video      (video),
      .rd_a_sel   (rd_a_sel),
      .rd_b_sel   (rd_b_sel),
      .rd_a_data  (rd_a_data),
      .rd_b_data  (rd_b_data),
      .wr_en      (wr_en),
      .wr_sel     (wr_sel),
      .wr_data    (wr_data),
      .cond       (cond),
      .take       (take)
   );

   register_file u_regs (
      .wire_clock (wire_clock),
      .resetStage (resetStage),
      .rd_a_sel   (rd_a_sel),
      .rd_b_sel   (rd_b_sel),
      .rd_a_data  (rd_a_data),
      .rd_b_data  (rd_b_data),
      .wr_en      (wr_en),
      .wr_sel     (wr_sel),
      .wr_data    (wr_data)
   );

   // flags come straight from the arithmetic unit
   branch_condition u_branch (
      .cond  (cond),
      .flags (flags),
      .take  (take)
   );

endmodule

// File: dv/cpu_core_properties.sv
`timescale 1ns/1ns

module cpu_core_properties (
   input logic              wire_clock,
   input logic              resetStage,
   input cpu_pkg::mem_req_t mem,
   input cpu_pkg::alu_req_t alu,
   input cpu_pkg::video_t   video
);
   import cpu_pkg::*;

   we_single: assert property (@(posedge wire_clock) disable iff (resetStage)
      mem.we |=> !mem.we)
      else $error("write strobe high for two cycles");

   video_pulse: assert property (@(posedge wire_clock) disable iff (resetStage)
      video.strobe |=> !video.strobe)
      else $error("video strobe longer than one cycle");

   // position and character settle before the strobe
   video_setup: assert property (@(posedge wire_clock) disable iff (resetStage)
      $rose(video.strobe) |-> $stable(video.pos) && $stable(video.character))
      else $error("video data changed with the strobe");

   alu_window: assert property (@(posedge wire_clock) disable iff (resetStage)
      $fell(alu.enable) |-> $past(alu.enable, ALU_DONE_STAGE - 1)
                            && !$past(alu.enable, ALU_DONE_STAGE))
      else $error("alu enable window has the wrong length");

   quiet_after_reset: assert property (@(posedge wire_clock)
      $fell(resetStage) |-> !mem.we && !alu.enable && !video.strobe)
      else $error("strobe active right after reset");

endmodule

bind cpu_core cpu_core_properties props (
   .wire_clock (wire_clock),
   .resetStage (resetStage),
   .mem        (mem),
   .alu        (alu),
   .video      (video)
);

// File: dv/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core;
   import cpu_pkg::*;

   typedef struct packed {
      logic [DATA_W-1:0] result;
      flags_t            fl;
   } alu_out_t;

   logic              wire_clock = 1'b0;
   logic              resetStage;
   mem_req_t          mem;
   logic [DATA_W-1:0] mem_rdata;
   alu_req_t          alu;
   logic [DATA_W-1:0] alu_result;
   flags_t            flags;
   video_t            video;

   logic [DATA_W-1:0] mem_array  [256];
   logic [DATA_W-1:0] prog_image [256];
   logic [7:0]        load_ptr;
   mem_req_t          wr_log  [16];
   video_t            vid_log [16];
   logic [7:0]        wr_count;
   logic [7:0]        vid_count;
   flags_t            flags_q;
   logic              en_d;
   alu_out_t          alu_now;
   int unsigned       seed = 29;
   int                errors = 0;
   int                checks = 0;
   int                tests_run = 0;
   int                tests_failed = 0;

   cpu_core dut (
      .wire_clock (wire_clock),
      .resetStage (resetStage),
      .mem        (mem),
      .mem_rdata  (mem_rdata),
      .alu        (alu),
      .alu_result (alu_result),
      .flags      (flags),
      .video      (video)
   );

   always #5 wire_clock = ~wire_clock;

   // memory with combinational read and a reload from the image during reset
   assign mem_rdata = mem_array[mem.addr[7:0]];

   always @(posedge wire_clock) begin
      if (resetStage) begin
         for (int i = 0; i < 256; i++) begin
            mem_array[i[7:0]] <= prog_image[i[7:0]];
         end
         wr_count  <= 8'd0;
         vid_count <= 8'd0;
      end else begin
         if (mem.we) begin
            mem_array[mem.addr[7:0]] <= mem.wdata;
            if (wr_count < 8'd16) begin
               wr_log[wr_count[3:0]] <= mem;
            end
            wr_count <= wr_count + 8'd1;
         end
         if (video.strobe) begin
            if (vid_count < 8'd16) begin
               vid_log[vid_count[3:0]] <= video;
            end
            vid_count <= vid_count + 8'd1;
         end
      end
   end

   // arithmetic unit model where only cmp changes the compare flags
   function automatic alu_out_t model_alu(input alu_req_t r, input flags_t prev);
      alu_out_t          o;
      logic [DATA_W:0]   wide;
      logic              cin;
      cin  = r.use_carry & prev.carry;
      o.fl = prev;
      o.result = '0;
      wide = '0;
      case (r.opcode)
         ADD: begin
            wide = {1'b0, r.a} + {1'b0, r.b} + {16'd0, cin};
            o.result = wide[DATA_W-1:0];
            o.fl.carry = wide[DATA_W];
            o.fl.overflow = (r.a[15] == r.b[15]) && (o.result[15] != r.a[15]);
         end
         SUB, CMP: begin
            wide = {1'b0, r.a} - {1'b0, r.b} - {16'd0, cin & (r.opcode == SUB)};
            o.result = wide[DATA_W-1:0];
            o.fl.carry = wide[DATA_W];
            o.fl.overflow = (r.a[15] != r.b[15]) && (o.result[15] != r.a[15]);
            if (r.opcode == CMP) begin
               o.fl.greater = r.a > r.b;
               o.fl.lesser  = r.a < r.b;
               o.fl.equal   = r.a == r.b;
            end
         end
         MUL: o.result = r.a * r.b;
         DIV, MOD: begin
            o.fl.divzero = (r.b == 16'd0);
            if (r.b != 16'd0) begin
               o.result = (r.opcode == DIV) ? r.a / r.b : r.a % r.b;
            end
         end
         AND: o.result = r.a & r.b;
         OR:  o.result = r.a | r.b;
         XOR: o.result = r.a ^ r.b;
         default: o.result = '0;
      endcase
      o.fl.zero = (o.result == 16'd0);
      o.fl.negative = o.result[15];
      return o;
   endfunction

   assign alu_now    = model_alu(alu, flags_q);
   assign alu_result = alu_now.result;
   assign flags      = (alu.enable || en_d) ? alu_now.fl : flags_q;

   always @(posedge wire_clock) begin
      if (resetStage) begin
         flags_q <= '0;
         en_d    <= 1'b0;
      end else begin
         en_d <= alu.enable;
         if (en_d && !alu.enable) begin
            flags_q <= alu_now.fl;
         end
      end
   end

   function automatic logic [15:0] next_rand();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed[30:15];
   endfunction

   function automatic logic [15:0] enc_mem(opcode_e op, logic [2:0] rx, logic [2:0] ry);
      instr_u w;
      w = '0;
      w.mem.opcode = op;
      w.mem.f.regs.rx = rx;
      w.mem.f.regs.ry = ry;
      return w;
   endfunction

   function automatic logic [15:0] enc_arith(opcode_e op, logic [2:0] rx, logic [2:0] ry,
                                             logic [2:0] rz, logic c);
      instr_u w;
      w = '0;
      w.arith.opcode = op;
      w.arith.rx = rx;
      w.arith.ry = ry;
      w.arith.rz = rz;
      w.arith.use_carry = c;
      return w;
   endfunction

   function automatic logic [15:0] enc_jump(cond_e c);
      instr_u w;
      w = '0;
      w.mem.opcode = JMP;
      w.mem.f.jump.cond = c;
      return w;
   endfunction

   // unknown opcode 0x28 in every unused word
   task automatic new_program();
      for (int i = 0; i < 256; i++) begin
         prog_image[i[7:0]] = 16'hA000 | {8'h00, i[7:0]};
      end
      load_ptr = 8'd0;
   endtask

   task automatic emit(input logic [15:0] w);
      prog_image[load_ptr] = w;
      load_ptr = load_ptr + 8'd1;
   endtask

   task automatic emit_halt();
      logic [7:0] here;
      here = load_ptr;
      emit(enc_jump(COND_ALWAYS));
      emit({8'h00, here});
   endtask

   task automatic apply_reset();
      @(posedge wire_clock);
      resetStage <= 1'b1;
      repeat (5) @(posedge wire_clock);
      resetStage <= 1'b0;
   endtask

   task automatic wait_writes(input logic [7:0] n, input string what);
      int cycles;
      cycles = 0;
      while (wr_count < n && cycles < 3000) begin
         @(negedge wire_clock);
         cycles++;
      end
      if (wr_count < n) begin
         $display("%s: timed out after %0d of %0d memory writes", what, wr_count, n);
         errors++;
      end
   endtask

   task automatic wait_strobes(input logic [7:0] n, input string what);
      int cycles;
      cycles = 0;
      while (vid_count < n && cycles < 3000) begin
         @(negedge wire_clock);
         cycles++;
      end
      if (vid_count < n) begin
         $display("%s: timed out waiting for the video strobe", what);
         errors++;
      end
   endtask

   task automatic check_mem_write(input string what, input mem_req_t got, input mem_req_t exp);
      checks++;
      if (got.addr !== exp.addr) begin
         $display("FAILED %s mem.addr got %h expected %h", what, got.addr, exp.addr);
         errors++;
      end
      if (got.wdata !== exp.wdata) begin
         $display("FAILED %s mem.wdata got %h expected %h", what, got.wdata, exp.wdata);
         errors++;
      end
   endtask

   task automatic check_video(input string what, input video_t got, input video_t exp);
      checks++;
      if (got.pos !== exp.pos) begin
         $display("FAILED %s video.pos got %h expected %h", what, got.pos, exp.pos);
         errors++;
      end
      if (got.character !== exp.character) begin
         $display("FAILED %s video.character got %h expected %h", what, got.character,
                  exp.character);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errs_before);
         tests_failed++;
      end
   endtask

   function automatic mem_req_t write_of(logic [15:0] a, logic [15:0] d);
      mem_req_t m;
      m.addr = a;
      m.wdata = d;
      m.we = 1'b1;
      return m;
   endfunction

   task automatic test_loadn_store();
      int          e0;
      logic [15:0] v;
      e0 = errors;
      v = next_rand();
      new_program();
      emit(enc_mem(LOADN, 3'd3, 3'd0));
      emit(v);
      emit(enc_mem(STORE, 3'd3, 3'd0));
      emit(16'h0080);
      emit_halt();
      apply_reset();
      wait_writes(8'd1, "loadn_store");
      check_mem_write("loadn_store", wr_log[0], write_of(16'h0080, v));
      report_test("loadn_store", e0);
   endtask

   task automatic test_load_mov_store();
      int          e0;
      logic [15:0] v;
      e0 = errors;
      v = next_rand();
      new_program();
      prog_image[8'h90] = v;
      emit(enc_mem(LOAD, 3'd1, 3'd0));
      emit(16'h0090);
      emit(enc_mem(MOV, 3'd5, 3'd1));
      emit(enc_mem(STORE, 3'd5, 3'd0));
      emit(16'h0091);
      emit_halt();
      apply_reset();
      wait_writes(8'd1, "load_mov_store");
      check_mem_write("load_mov_store", wr_log[0], write_of(16'h0091, v));
      report_test("load_mov_store", e0);
   endtask

   function automatic logic [15:0] expected_alu(opcode_e op, logic [15:0] a, logic [15:0] b);
      case (op)
         ADD: return a + b;
         SUB: return a - b;
         MUL: return a * b;
         DIV: return a / b;
         MOD: return a % b;
         AND: return a & b;
         OR:  return a | b;
         XOR: return a ^ b;
         default: return 16'd0;
      endcase
   endfunction

   task automatic test_arith();
      opcode_e     ops [8] = '{ADD, SUB, MUL, DIV, MOD, AND, OR, XOR};
      logic [15:0] av [9];
      logic [15:0] bv [9];
      int          e0;
      e0 = errors;
      new_program();
      for (int k = 0; k < 8; k++) begin
         av[k] = next_rand();
         // small nonzero divisor
         bv[k] = (next_rand() & 16'h00FF) | 16'h0001;
         emit(enc_mem(LOADN, 3'd1, 3'd0));
         emit(av[k]);
         emit(enc_mem(LOADN, 3'd2, 3'd0));
         emit(bv[k]);
         emit(enc_arith(ops[k], 3'd1, 3'd2, 3'd4, 1'b0));
         emit(enc_mem(STORE, 3'd4, 3'd0));
         emit(16'h00A0 + 16'(k));
      end
      // a below b leaves the borrow set for addc
      av[8] = next_rand() & 16'h7FFF;
      bv[8] = av[8] | 16'h8000;
      emit(enc_mem(LOADN, 3'd1, 3'd0));
      emit(av[8]);
      emit(enc_mem(LOADN, 3'd2, 3'd0));
      emit(bv[8]);
      emit(enc_arith(CMP, 3'd1, 3'd2, 3'd0, 1'b0));
      emit(enc_arith(ADD, 3'd1, 3'd2, 3'd4, 1'b1));
      emit(enc_mem(STORE, 3'd4, 3'd0));
      emit(16'h00A8);
      emit_halt();
      apply_reset();
      wait_writes(8'd9, "arith");
      for (int k = 0; k < 8; k++) begin
         check_mem_write(ops[k].name(), wr_log[k],
                         write_of(16'h00A0 + 16'(k), expected_alu(ops[k], av[k], bv[k])));
      end
      check_mem_write("ADDC", wr_log[8], write_of(16'h00A8, av[8] + bv[8] + 16'd1));
      report_test("arith", e0);
   endtask

   function automatic logic expected_take(int c, logic [15:0] x, logic [15:0] y);
      logic [15:0] d;
      logic        ovf;
      d = x - y;
      ovf = (x[15] != y[15]) && (d[15] != x[15]);
      case (c)
         0:  return 1'b1;
         1:  return x == y;
         2:  return x != y;
         3:  return d == 16'd0;
         4:  return d != 16'd0;
         5:  return x < y;
         6:  return x >= y;
         7:  return x > y;
         8:  return x < y;
         9:  return x >= y;
         10: return x <= y;
         11: return ovf;
         12: return !ovf;
         13: return d[15];
         default: return 1'b0;
      endcase
   endfunction

   task automatic test_jumps();
      int          e0;
      logic [15:0] x;
      logic [15:0] y;
      logic [7:0]  target;
      logic        taken;
      e0 = errors;
      for (int c = 0; c < 15; c++) begin
         for (int rel = 0; rel < 3; rel++) begin
            x = (next_rand() & 16'h3FFF) + 16'h0100;
            case (rel)
               0: y = x - 16'd1 - (next_rand() & 16'h00FF);
               1: y = x;
               default: y = x + 16'd1 + (next_rand() & 16'h00FF);
            endcase
            taken = expected_take(c, x, y);
            new_program();
            emit(enc_mem(LOADN, 3'd1, 3'd0));
            emit(x);
            emit(enc_mem(LOADN, 3'd2, 3'd0));
            emit(y);
            emit(enc_arith(CMP, 3'd1, 3'd2, 3'd0, 1'b0));
            emit(enc_jump(cond_e'(c[3:0])));
            target = load_ptr + 8'd5;
            emit({8'h00, target});
            emit(enc_mem(STORE, 3'd1, 3'd0));
            emit(16'h00C0);
            emit_halt();
            emit(enc_mem(STORE, 3'd1, 3'd0));
            emit(16'h00C1);
            emit_halt();
            apply_reset();
            wait_writes(8'd1, "jumps");
            check_mem_write($sformatf("jump cond %0d", c), wr_log[0],
                            write_of(taken ? 16'h00C1 : 16'h00C0, x));
         end
      end
      report_test("jumps", e0);
   endtask

   task automatic test_outchar();
      int          e0;
      video_t      exp;
      e0 = errors;
      exp.strobe = 1'b1;
      exp.character = next_rand() & 16'h00FF;
      exp.pos = next_rand() & 16'h03FF;
      new_program();
      emit(enc_mem(LOADN, 3'd6, 3'd0));
      emit(exp.character);
      emit(enc_mem(LOADN, 3'd7, 3'd0));
      emit(exp.pos);
      emit(enc_mem(OUTCHAR, 3'd6, 3'd7));
      emit_halt();
      apply_reset();
      wait_strobes(8'd1, "outchar");
      check_video("outchar", vid_log[0], exp);
      report_test("outchar", e0);
   endtask

   task automatic test_mid_reset();
      int          e0;
      logic [15:0] v1;
      e0 = errors;
      v1 = next_rand();
      new_program();
      emit(enc_mem(LOADN, 3'd2, 3'd0));
      emit(v1);
      emit(enc_mem(STORE, 3'd2, 3'd0));
      emit(16'h00D0);
      emit(enc_mem(LOADN, 3'd2, 3'd0));
      emit(next_rand());
      emit(enc_mem(STORE, 3'd2, 3'd0));
      emit(16'h00D1);
      emit_halt();
      apply_reset();
      wait_writes(8'd1, "mid_reset");
      check_mem_write("mid_reset first run", wr_log[0], write_of(16'h00D0, v1));
      // second store still in flight here
      apply_reset();
      wait_writes(8'd1, "mid_reset");
      check_mem_write("mid_reset restart", wr_log[0], write_of(16'h00D0, v1));
      report_test("mid_reset", e0);
   endtask

   initial begin
      resetStage = 1'b1;
      test_loadn_store();
      test_load_mov_store();
      test_arith();
      test_jumps();
      test_outchar();
      test_mid_reset();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: build.f
src/cpu_pkg.sv
src/register_file.sv
src/branch_condition.sv
src/instr_sequencer.sv
src/cpu_core.sv
dv/cpu_core_properties.sv
dv/tb_cpu_core.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f build.f --top-module tb_cpu_core -o sim_tb; then
   echo "compile failed"
   exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -q "Result: PASSED" sim.log; then
   exit 0
fi
exit 1
